/* sources.f */
verilog/nodeReturnPkg.sv
verilog/nodeControl.sv
verilog/returnFifo.sv
verilog/returnArbiter.sv
verilog/nodeReturnPath.sv
verif/returnChecker.sv
verif/tbNodeReturnPath.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tbNodeReturnPath \
	-o simNodeReturnPath

output=$(./obj_dir/simNodeReturnPath)
echo "$output"

echo "$output" | grep -qx "sim passed"

/* verif/tbNodeReturnPath.sv */
`timescale 1ns/10ps

module tbNodeReturnPath;

	import nodeReturnPkg::*;

	localparam int TickScale = 20;
	localparam int FifoDepth = 16;

	typedef struct packed {
		logic [2:0] testId;
		returnSource_e src;
		logic alsoNet;
		logic [7:0] tag;
		logic [2:0] size;
		logic [7:0] idle;
		logic [4:0] burst;
	} stimRow_t;

	localparam int NumRows = 11;

	// test, source, net word in same cycle, tag, size, idle after, burst length
	localparam stimRow_t StimTable [NumRows] = '{
		'{3'd1, srcNet, 1'b0, 8'h01, 3'd3, 8'd2, 5'd1},
		'{3'd1, srcStream, 1'b0, 8'h10, 3'd2, 8'd0, 5'd3},
		'{3'd1, srcLocal, 1'b0, 8'h18, 3'd1, 8'd1, 5'd2},
		'{3'd1, srcNet, 1'b0, 8'h28, 3'd0, 8'd0, 5'd4},
		'{3'd1, srcStream, 1'b0, 8'h30, 3'd7, 8'd3, 5'd1},
		'{3'd1, srcLocal, 1'b0, 8'h38, 3'd3, 8'd0, 5'd1},
		'{3'd1, srcStream, 1'b1, 8'h40, 3'd4, 8'd4, 5'd2},
		'{3'd1, srcNet, 1'b0, 8'h48, 3'd5, 8'd5, 5'd1},
		'{3'd2, srcStream, 1'b1, 8'h60, 3'd1, 8'd0, 5'd1},
		'{3'd2, srcLocal, 1'b0, 8'h61, 3'd2, 8'd6, 5'd1},
		'{3'd3, srcStream, 1'b1, 8'h70, 3'd6, 8'd2, 5'd16}
	};

	logic EXTCLK;
	logic reset;
	logic msgrResetReq;
	logic contextResetReq;
	logic intReq;
	logic intAck;
	logic intEnable;
	logic coreEmpty;
	logic msgBreakpoint;
	logic streamWrite;
	returnWord_t streamWord;
	logic netWrite;
	returnWord_t netWord;
	logic localReady;
	returnWord_t localWord;
	logic localRead;
	logic coreReady;
	returnWord_t coreWord;
	logic tick;
	logic coreStop;
	logic msgIntReq;
	int errorCount;
	int checkCount;
	int pendingCount;
	int errorsBefore = 0;
	int cycleCount = 0;
	logic [31:0] lfsrState = 32'd70841;

	nodeReturnPath #(.TickScale(TickScale), .FifoDepth(FifoDepth)) u_nodeReturnPath (.*);

	returnChecker #(.TickScale(TickScale)) u_checker (.*);

	initial
	begin
		EXTCLK = 1'b0;
		forever #4 EXTCLK = ~EXTCLK;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [63:0] drawBits(input int count);
		logic [63:0] value;
		logic feedback;
		value = '0;
		for (int k = 0; k < count; k++)
		begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[62:0], feedback};
		end
		return value;
	endfunction

	function automatic returnWord_t makeWord(input logic [7:0] tag, input logic [2:0] size);
		returnWord_t word;
		word.size = size;
		word.tag = tag;
		word.data = drawBits(64);
		return word;
	endfunction

	function automatic int tableCycles();
		int total;
		total = 0;
		foreach (StimTable[i])
			total += int'(StimTable[i].burst) + int'(StimTable[i].idle);
		return total;
	endfunction

	function automatic string testName(input int id);
		case (id)
			1: return "per-source order";
			2: return "priority";
			3: return "FIFO depth";
			4: return "tick";
			default: return "interrupt and reset";
		endcase
	endfunction

	// one rising edge, strobes back low
	task automatic nextCycle();
		@(posedge EXTCLK);
		streamWrite <= 1'b0;
		netWrite <= 1'b0;
		intReq <= 1'b0;
		intAck <= 1'b0;
		msgrResetReq <= 1'b0;
	endtask

	task automatic applyRow(input stimRow_t row);
		returnWord_t word;
		for (int n = 0; n < int'(row.burst); n++)
		begin
			nextCycle();
			word = makeWord(row.tag + 8'(n), row.size);
			if (row.alsoNet)
			begin
				netWrite <= 1'b1;
				netWord <= makeWord((row.tag + 8'(n)) | 8'h80, row.size);
			end
			if (row.src == srcNet)
			begin
				netWrite <= 1'b1;
				netWord <= word;
			end
			else if (row.src == srcStream)
			begin
				streamWrite <= 1'b1;
				streamWord <= word;
			end
			else
			begin
				localReady <= 1'b1;
				localWord <= word;
				// held until the arbiter takes it
				do
					nextCycle();
				while (!localRead);
				localReady <= 1'b0;
			end
		end
		repeat (row.idle) nextCycle();
	endtask

	task automatic waitDrain();
		repeat (2) nextCycle();
		while (pendingCount != 0)
			nextCycle();
	endtask

	task automatic waitTicks(input int count);
		repeat (count)
		begin
			do
				nextCycle();
			while (!tick);
		end
	endtask

	task automatic reportTest(input int id);
		int newErrors;
		repeat (2) nextCycle();
		newErrors = errorCount - errorsBefore;
		$display("test %0d %s: %0d errors", id, testName(id), newErrors);
		errorsBefore = errorCount;
	endtask

	// ====================
	// test sequence
	// ====================

	initial
	begin
		reset <= 1'b1;
		msgrResetReq <= 1'b0;
		contextResetReq <= 1'b0;
		intReq <= 1'b0;
		intAck <= 1'b0;
		intEnable <= 1'b1;
		coreEmpty <= 1'b1;
		msgBreakpoint <= 1'b0;
		streamWrite <= 1'b0;
		streamWord <= '0;
		netWrite <= 1'b0;
		netWord <= '0;
		localReady <= 1'b0;
		localWord <= '0;
		repeat (10) nextCycle();
		reset <= 1'b0;
		for (int i = 0; i < NumRows; i++)
		begin
			applyRow(StimTable[i]);
			if (i == NumRows - 1 || StimTable[i + 1].testId != StimTable[i].testId)
			begin
				waitDrain();
				reportTest(int'(StimTable[i].testId));
			end
		end
		// three pulses give two full gaps
		waitTicks(3);
		reportTest(4);
		nextCycle();
		intReq <= 1'b1;
		do
			nextCycle();
		while (!coreStop);
		do
			nextCycle();
		while (!msgIntReq);
		repeat (4) nextCycle();
		intAck <= 1'b1;
		do
			nextCycle();
		while (coreStop);
		// second episode ended by a messenger reset
		intReq <= 1'b1;
		do
			nextCycle();
		while (!coreStop);
		do
			nextCycle();
		while (!msgIntReq);
		repeat (3) nextCycle();
		msgrResetReq <= 1'b1;
		do
			nextCycle();
		while (coreStop);
		waitTicks(2);
		reportTest(5);
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// watchdog
	initial
	begin
		int limit;
		limit = 2 * tableCycles() + 200;
		while (cycleCount < limit)
		begin
			@(posedge EXTCLK);
			cycleCount++;
		end
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("sim failed");
		$finish;
	end

endmodule

/* verif/returnChecker.sv */
`timescale 1ns/10ps

module returnChecker #(
	parameter int TickScale = 20
) (
	input logic EXTCLK,
	// any of these restarts the tick count
	input logic reset,
	input logic msgrResetReq,
	input logic contextResetReq,
	input logic streamWrite,
	input nodeReturnPkg::returnWord_t streamWord,
	input logic netWrite,
	input nodeReturnPkg::returnWord_t netWord,
	// localRead is only ever high while localReady is
	input nodeReturnPkg::returnWord_t localWord,
	input logic localRead,
	input logic coreReady,
	input nodeReturnPkg::returnWord_t coreWord,
	input logic tick,
	input logic coreStop,
	input logic msgIntReq,
	output int errorCount,
	output int checkCount,
	output int pendingCount
);

	import nodeReturnPkg::*;

	// expected word and the sample it was written on
	typedef struct packed {
		logic [31:0] cycle;
		returnWord_t word;
	} expEntry_t;

	expEntry_t netQ[$];
	expEntry_t streamQ[$];
	expEntry_t localQ[$];
	int sampleCount = 0;
	int errors = 0;
	int checks = 0;
	int tickGap = 0;
	int stopPulses = 0;
	logic firstTick = 1'b1;
	// reset request seen on the previous edge
	logic resetHeld = 1'b1;
	logic prevStop = 1'b0;
	logic prevMsg = 1'b0;

	task automatic flagError(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	always @(posedge EXTCLK)
	begin
		logic netDue;
		logic streamDue;
		// a FIFO word can reach the core two samples after its write
		netDue = (netQ.size() > 0) && (int'(netQ[0].cycle) <= sampleCount - 2);
		streamDue = (streamQ.size() > 0) && (int'(streamQ[0].cycle) <= sampleCount - 2);

		// ====================
		// priority, order and integrity of one core word
		if (coreReady)
		begin
			checks++;
			if (netDue && coreWord == netQ[0].word)
				void'(netQ.pop_front());
			else if (!netDue && streamDue && coreWord == streamQ[0].word)
				void'(streamQ.pop_front());
			else if (!netDue && !streamDue && localQ.size() > 0
				&& coreWord == localQ[0].word)
				void'(localQ.pop_front());
			else
				flagError($sformatf("core word tag %h size %0d data %h out of order",
					coreWord.tag, coreWord.size, coreWord.data));
		end
		if (netWrite)
			netQ.push_back({32'(sampleCount), netWord});
		if (streamWrite)
			streamQ.push_back({32'(sampleCount), streamWord});
		if (localRead)
			localQ.push_back({32'(sampleCount), localWord});

		// ====================
		// tick spacing, a tick already raised before the node reset still counts
		tickGap++;
		if (tick)
		begin
			checks++;
			// first gap also spans the edge that samples the tick
			if (tickGap != (firstTick ? TickScale + 1 : TickScale))
				flagError($sformatf("tick gap %0d cycles, expected %0d", tickGap,
					firstTick ? TickScale + 1 : TickScale));
			tickGap = 0;
			firstTick = 1'b0;
		end
		// node reset follows the request by one cycle
		if (resetHeld)
		begin
			tickGap = 0;
			firstTick = 1'b1;
		end
		resetHeld = reset || msgrResetReq || contextResetReq;

		// one message request per stop episode, core kept empty
		if (coreStop && !prevStop)
			stopPulses = 0;
		if (msgIntReq && (coreStop || prevStop))
			stopPulses++;
		if (msgIntReq && prevMsg)
			flagError("msgIntReq high two cycles in a row");
		if (prevStop && !coreStop)
		begin
			checks++;
			if (stopPulses != 1)
				flagError($sformatf("%0d msgIntReq pulses in stop episode, expected 1",
					stopPulses));
		end
		prevStop = coreStop;
		prevMsg = msgIntReq;
		sampleCount++;
		errorCount <= errors;
		checkCount <= checks;
		pendingCount <= netQ.size() + streamQ.size() + localQ.size();
	end

endmodule

/* verilog/nodeReturnPath.sv */
`timescale 1ns/10ps

module nodeReturnPath #(
	parameter int TickScale = 20,
	parameter int FifoDepth = 16
) (
	input logic EXTCLK,
	input logic reset,
	// reset requests from subsystems
	input logic msgrResetReq,
	input logic contextResetReq,
	// interrupt interface
	input logic intReq,
	input logic intAck,
	input logic intEnable,
	// core status
	input logic coreEmpty,
	input logic msgBreakpoint,
	// stream return channel
	input logic streamWrite,
	input nodeReturnPkg::returnWord_t streamWord,
	// network return channel
	input logic netWrite,
	input nodeReturnPkg::returnWord_t netWord,
	// local memory return channel
	input logic localReady,
	input nodeReturnPkg::returnWord_t localWord,
	output logic localRead,
	// return data toward the core
	output logic coreReady,
	output nodeReturnPkg::returnWord_t coreWord,
	// control outputs
	output logic tick,
	output logic coreStop,
	output logic msgIntReq
);

	import nodeReturnPkg::*;

	logic sysReset;

	logic streamEmpty;
	logic streamRead;
	returnWord_t streamHead;

	logic netEmpty;
	logic netRead;
	returnWord_t netHead;

	// ====================
	// reset, tick and interrupt glue
	// ====================

	nodeControl #(
		.TickScale(TickScale)
	) u_control (
		.EXTCLK(EXTCLK),
		.reset(reset),
		.msgrResetReq(msgrResetReq),
		.contextResetReq(contextResetReq),
		.intReq(intReq),
		.intAck(intAck),
		.intEnable(intEnable),
		.coreEmpty(coreEmpty),
		.msgBreakpoint(msgBreakpoint),
		.sysReset(sysReset),
		.tick(tick),
		.coreStop(coreStop),
		.msgIntReq(msgIntReq)
	);

	// ====================
	// return FIFOs
	// ====================

	returnFifo #(
		.FifoDepth(FifoDepth)
	) u_streamFifo (
		.EXTCLK(EXTCLK),
		.sysReset(sysReset),
		.write(streamWrite),
		.writeWord(streamWord),
		.read(streamRead),
		.empty(streamEmpty),
		.head(streamHead)
	);

	returnFifo #(
		.FifoDepth(FifoDepth)
	) u_netFifo (
		.EXTCLK(EXTCLK),
		.sysReset(sysReset),
		.write(netWrite),
		.writeWord(netWord),
		.read(netRead),
		.empty(netEmpty),
		.head(netHead)
	);

	// network first, then stream, then local
	returnArbiter u_arbiter (
		.EXTCLK(EXTCLK),
		.sysReset(sysReset),
		.netEmpty(netEmpty),
		.netHead(netHead),
		.netRead(netRead),
		.streamEmpty(streamEmpty),
		.streamHead(streamHead),
		.streamRead(streamRead),
		.localReady(localReady),
		.localWord(localWord),
		.localRead(localRead),
		.coreReady(coreReady),
		.coreWord(coreWord)
	);

endmodule

/* verilog/returnArbiter.sv */
`timescale 1ns/10ps

module returnArbiter (
	input logic EXTCLK,
	input logic sysReset,
	// network FIFO, highest priority
	input logic netEmpty,
	input nodeReturnPkg::returnWord_t netHead,
	output logic netRead,
	// stream FIFO, middle priority
	input logic streamEmpty,
	input nodeReturnPkg::returnWord_t streamHead,
	output logic streamRead,
	// local memory channel, lowest priority
	input logic localReady,
	input nodeReturnPkg::returnWord_t localWord,
	output logic localRead,
	// toward the core
	output logic coreReady,
	output nodeReturnPkg::returnWord_t coreWord
);

	import nodeReturnPkg::*;

	returnSource_e grant;
	returnSource_e grantReg;
	returnWord_t selectedWord;

	// ====================
	// priority select
	// ====================

	always_comb
	begin
		if (!netEmpty)
		begin
			grant = srcNet;
		end
		else if (!streamEmpty)
		begin
			grant = srcStream;
		end
		else if (localReady)
		begin
			grant = srcLocal;
		end
		else
		begin
			grant = srcNone;
		end
	end

	// read strobes take effect at the same edge as the output register
	assign netRead = (grant == srcNet);
	assign streamRead = (grant == srcStream);
	assign localRead = (grant == srcLocal);

	always_comb
	begin
		case (grant)
			srcNet: selectedWord = netHead;
			srcStream: selectedWord = streamHead;
			default: selectedWord = localWord;
		endcase
	end

	// ====================
	// output register
	// ====================

	// registered grant doubles as the core strobe
	always_ff @(posedge EXTCLK)
	begin
		if (sysReset)
		begin
			grantReg <= srcNone;
		end
		else
		begin
			grantReg <= grant;
		end
	end

	// word only loads when something was granted
	always_ff @(posedge EXTCLK)
	begin
		if (grant != srcNone)
		begin
			coreWord <= selectedWord;
		end
	end

	assign coreReady = (grantReg != srcNone);

	// one source is served per cycle across all three channels
	singleReadStrobe: assert property (
		@(posedge EXTCLK) disable iff (sysReset)
		$onehot0({netRead, streamRead, localRead})
	) else $error("more than one return source read in one cycle");

endmodule

/* verilog/returnFifo.sv */
`timescale 1ns/10ps

module returnFifo #(
	parameter int FifoDepth = 16
) (
	input logic EXTCLK,
	input logic sysReset,
	// write side, one word per strobe
	input logic write,
	input nodeReturnPkg::returnWord_t writeWord,
	// read side toward the arbiter
	input logic read,
	output logic empty,
	output nodeReturnPkg::returnWord_t head
);

	import nodeReturnPkg::*;

	localparam int AddrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
	localparam logic [AddrWidth:0] FullCount = (AddrWidth + 1)'(FifoDepth);

	returnWord_t storage [FifoDepth];

	logic [AddrWidth-1:0] wrPtr;
	logic [AddrWidth-1:0] rdPtr;
	logic [AddrWidth:0] fillCount;
	logic full;
	logic wrEn;
	logic rdEn;

	assign full = (fillCount == FullCount);
	assign empty = (fillCount == '0);

	// a bad strobe must not corrupt the pointers
	assign wrEn = write & ~full;
	assign rdEn = read & ~empty;

	// oldest word is visible without a read
	assign head = storage[rdPtr];

	// ====================
	// storage
	// ====================

	always_ff @(posedge EXTCLK)
	begin
		if (wrEn)
		begin
			storage[wrPtr] <= writeWord;
		end
	end

	// ====================
	// pointers and fill count
	// ====================

	always_ff @(posedge EXTCLK)
	begin
		if (sysReset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			fillCount <= '0;
		end
		else
		begin
			if (wrEn)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (rdEn)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({wrEn, rdEn})
				2'b10: fillCount <= fillCount + 1'b1;
				2'b01: fillCount <= fillCount - 1'b1;
				default: fillCount <= fillCount;
			endcase
		end
	end

	// sources have no back-pressure, so they must never overrun
	noWriteWhenFull: assert property (
		@(posedge EXTCLK) disable iff (sysReset)
		write |-> !full
	) else $error("return FIFO written while full");

	// the arbiter only reads a channel it saw as non-empty
	noReadWhenEmpty: assert property (
		@(posedge EXTCLK) disable iff (sysReset)
		read |-> !empty
	) else $error("return FIFO read while empty");

endmodule

/* verilog/nodeControl.sv */
`timescale 1ns/10ps

module nodeControl #(
	parameter int TickScale = 20
) (
	input logic EXTCLK,
	input logic reset,
	// reset requests from the messenger and the context controller
	input logic msgrResetReq,
	input logic contextResetReq,
	// interrupt request and acknowledge
	input logic intReq,
	input logic intAck,
	input logic intEnable,
	// core status
	input logic coreEmpty,
	input logic msgBreakpoint,
	output logic sysReset,
	output logic tick,
	output logic coreStop,
	output logic msgIntReq
);

	// counter wide enough to hold TickScale-1
	localparam int CountWidth = (TickScale > 1) ? $clog2(TickScale) : 1;
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(TickScale - 1);

	logic [CountWidth-1:0] tickCount;
	logic tickDue;
	logic intIssued;
	logic intLaunch;

	// ====================
	// reset filter
	// ====================

	// any request holds the node in reset for the following cycle
	always_ff @(posedge EXTCLK)
	begin
		sysReset <= reset | msgrResetReq | contextResetReq;
	end

	// ====================
	// tick generator
	// ====================

	assign tickDue = (tickCount == LastCount);

	// counter wraps on the cycle it raises the tick
	always_ff @(posedge EXTCLK)
	begin
		if (sysReset)
		begin
			tickCount <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tickCount <= tickDue ? '0 : tickCount + 1'b1;
			tick <= tickDue;
		end
	end

	// ====================
	// interrupt sequencer
	// ====================

	// message request only once the core has drained
	assign intLaunch = coreStop & coreEmpty & ~msgBreakpoint & ~intIssued;

	always_ff @(posedge EXTCLK)
	begin
		if (sysReset)
		begin
			coreStop <= 1'b0;
			msgIntReq <= 1'b0;
			intIssued <= 1'b0;
		end
		else
		begin
			// stop flag held until acknowledged or disabled
			coreStop <= (coreStop | intReq) & ~intAck & intEnable;
			msgIntReq <= intLaunch;
			// one request per stop episode
			intIssued <= (intIssued | intLaunch) & coreStop;
		end
	end

	// the messenger sees a single-cycle request per episode
	msgIntSinglePulse: assert property (
		@(posedge EXTCLK) disable iff (sysReset)
		msgIntReq |=> !msgIntReq
	) else $error("msgIntReq high on two consecutive cycles");

endmodule

/* verilog/nodeReturnPkg.sv */
package nodeReturnPkg;

	// ====================
	// return path widths
	// ====================

	// data word returned to the core
	localparam int DataWidth = 64;

	// core transaction tag
	localparam int TagWidth = 8;

	// size code of the returned word
	localparam int SizeWidth = 3;

	// ====================
	// return word
	// ====================

	// size sits on top, data at the bottom, 75 bits in all
	typedef struct packed {
		logic [SizeWidth-1:0] size;
		logic [TagWidth-1:0] tag;
		logic [DataWidth-1:0] data;
	} returnWord_t;

	// ====================
	// return sources
	// ====================

	// grant of the return arbiter
	// srcNone means no word this cycle
	typedef enum logic [1:0] {
		srcNone = 2'd0,
		srcLocal = 2'd1,
		srcStream = 2'd2,
		srcNet = 2'd3
	} returnSource_e;

endpackage
